// ==== design/isaPkg.sv ====
`default_nettype none

package isaPkg;

    // Primary opcode field
    typedef enum logic [5:0] {
        OPC_R_TYPE = 6'b000000,
        OPC_J      = 6'b000010,
        OPC_JAL    = 6'b000011,
        OPC_BEQ    = 6'b000100,
        OPC_BNE    = 6'b000101,
        OPC_BLE    = 6'b000110,
        OPC_BGT    = 6'b000111,
        OPC_ADDI   = 6'b001000,
        OPC_ADDIU  = 6'b001001
    } opcodeT;

    // Function field, meaningful for R-type only
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_MFHI = 6'b010000,
        FN_MFLO = 6'b010010,
        FN_MULT = 6'b011000,
        FN_DIV  = 6'b011010,
        FN_ADD  = 6'b100000,
        FN_SUB  = 6'b100010,
        FN_AND  = 6'b100100,
        FN_SLT  = 6'b101010
    } functT;

    typedef struct packed {
        opcodeT opcode;
        functT  funct;
    } instrFieldsT;

    // One class per distinct control sequence
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        SET_LESS,
        JUMP_REG,
        MOVE_HI,
        MOVE_LO,
        MULTIPLY,
        DIVIDE,
        JUMP,
        JUMP_LINK,
        ADD_IMM,
        BR_EQ,
        BR_NE,
        BR_LE,
        BR_GT,
        ILLEGAL
    } instrClassT;

endpackage

`default_nettype wire

// ==== design/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    typedef enum logic [3:0] {
        FETCH_ISSUE,
        FETCH_WAIT,
        FETCH_LOAD,
        DECODE,
        EXECUTE,
        ALU_WRITEBACK,
        LINK_WRITE,
        BRANCH_RESOLVE,
        MULDIV_WAIT,
        HILO_WRITE,
        EXCEPTION
    } stateT;

    // PC input mux
    typedef enum logic [2:0] {
        PC_ALU_RESULT,
        PC_ALU_OUT,
        PC_JUMP_TARGET,
        PC_REG_A,
        PC_EXC_VECTOR
    } pcSourceT;

    typedef enum logic [2:0] {
        OP_PASS_A  = 3'b000,
        OP_ADD     = 3'b001,
        OP_SUB     = 3'b010,
        OP_AND     = 3'b011,
        OP_COMPARE = 3'b111
    } aluOpT;

    typedef enum logic {
        SRCA_PC,
        SRCA_REG_A
    } aluSrcAT;

    typedef enum logic [1:0] {
        SRCB_REG_B,
        SRCB_CONST_FOUR,
        SRCB_IMMEDIATE,
        SRCB_BRANCH_OFFSET
    } aluSrcBT;

    // Register file write port, address and data
    typedef enum logic [1:0] {
        DEST_RT,
        DEST_RD,
        DEST_RA
    } regDestT;

    typedef enum logic [1:0] {
        DATA_ALU_OUT,
        DATA_HILO,
        DATA_LESS_FLAG
    } regDataT;

    typedef struct packed {
        logic overflow;
        logic eq;
        logic gt;
    } aluFlagsT;

    typedef struct packed {
        logic     pcWrite;
        pcSourceT pcSource;
        logic     irWrite;
        aluOpT    aluOp;
        aluSrcAT  aluSrcA;
        aluSrcBT  aluSrcB;
        logic     regAWrite;
        logic     regBWrite;
        logic     aluOutWrite;
        logic     regWrite;
        regDestT  regDest;
        regDataT  regData;
        logic     hiLoSelect;   // 0 reads hi
        logic     hiLoFromDiv;
        logic     hiWrite;
        logic     loWrite;
        logic     multOp;
        logic     divOp;
    } controlWordT;

endpackage

`default_nettype wire

// ==== design/instrDecoder.sv ====
`default_nettype none
`timescale 1ns/10ps

module instrDecoder (
    input  isaPkg::instrFieldsT instr,
    output isaPkg::instrClassT  instrClass
);
    import isaPkg::*;

    always_comb begin
        instrClass = ILLEGAL;
        case (instr.opcode)
            OPC_R_TYPE: begin
                case (instr.funct)
                    FN_ADD: begin
                        instrClass = ALU_ADD;
                    end
                    FN_SUB: begin
                        instrClass = ALU_SUB;
                    end
                    FN_AND: begin
                        instrClass = ALU_AND;
                    end
                    FN_SLT: begin
                        instrClass = SET_LESS;
                    end
                    FN_JR: begin
                        instrClass = JUMP_REG;
                    end
                    FN_MFHI: begin
                        instrClass = MOVE_HI;
                    end
                    FN_MFLO: begin
                        instrClass = MOVE_LO;
                    end
                    FN_MULT: begin
                        instrClass = MULTIPLY;
                    end
                    FN_DIV: begin
                        instrClass = DIVIDE;
                    end
                    default: begin
                        instrClass = ILLEGAL;
                    end
                endcase
            end
            OPC_J: begin
                instrClass = JUMP;
            end
            OPC_JAL: begin
                instrClass = JUMP_LINK;
            end
            // Same control flow for both, overflow is left to the datapath
            OPC_ADDI, OPC_ADDIU: begin
                instrClass = ADD_IMM;
            end
            OPC_BEQ: begin
                instrClass = BR_EQ;
            end
            OPC_BNE: begin
                instrClass = BR_NE;
            end
            OPC_BLE: begin
                instrClass = BR_LE;
            end
            OPC_BGT: begin
                instrClass = BR_GT;
            end
            default: begin
                instrClass = ILLEGAL;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/sequencer.sv ====
`default_nettype none
`timescale 1ns/10ps

module sequencer #(
    parameter int memLatency = 2
) (
    input  logic               clock,
    input  logic               rstN,
    input  isaPkg::instrClassT instrClass,
    input  logic               overflow,
    input  logic               multDone,
    input  logic               divDone,
    output ctrlPkg::stateT     state,
    output isaPkg::instrClassT heldClass
);
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int cntWidth = $clog2(memLatency + 1);

    stateT               nextState;
    logic [cntWidth-1:0] waitCount;
    logic                fetchDone;
    logic                mulDivDone;

    // Last wait cycle before the memory word is ready
    assign fetchDone = (waitCount == cntWidth'(memLatency - 2));

    assign mulDivDone = (heldClass == MULTIPLY) ? multDone : divDone;

    always_comb begin
        nextState = state;
        case (state)
            FETCH_ISSUE: begin
                if (memLatency > 1) begin
                    nextState = FETCH_WAIT;
                end else begin
                    nextState = FETCH_LOAD;
                end
            end
            FETCH_WAIT: begin
                if (fetchDone) begin
                    nextState = FETCH_LOAD;
                end
            end
            FETCH_LOAD: begin
                nextState = DECODE;
            end
            DECODE: begin
                nextState = EXECUTE;
            end
            EXECUTE: begin
                case (heldClass)
                    ALU_ADD, ALU_SUB, ALU_AND, ADD_IMM: begin
                        if (overflow) begin
                            nextState = EXCEPTION;
                        end else begin
                            nextState = ALU_WRITEBACK;
                        end
                    end
                    JUMP_LINK: begin
                        nextState = LINK_WRITE;
                    end
                    BR_EQ, BR_NE, BR_LE, BR_GT: begin
                        nextState = BRANCH_RESOLVE;
                    end
                    MULTIPLY, DIVIDE: begin
                        nextState = MULDIV_WAIT;
                    end
                    ILLEGAL: begin
                        nextState = EXCEPTION;
                    end
                    default: begin
                        nextState = FETCH_ISSUE;
                    end
                endcase
            end
            // No timeout here, the unit decides how long this takes
            MULDIV_WAIT: begin
                if (mulDivDone) begin
                    nextState = HILO_WRITE;
                end
            end
            default: begin
                nextState = FETCH_ISSUE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state     <= FETCH_ISSUE;
            waitCount <= '0;
            heldClass <= ILLEGAL;
        end else begin
            state <= nextState;
            if (state == FETCH_WAIT && !fetchDone) begin
                waitCount <= waitCount + 1'b1;
            end else begin
                waitCount <= '0;
            end
            // instr is stable by now, keep its class for the rest of the instruction
            if (state == DECODE) begin
                heldClass <= instrClass;
            end
        end
    end

    // Multiplier and divider never finish together
    assert property (@(posedge clock) disable iff (!rstN)
        (state == MULDIV_WAIT) |-> !(multDone && divDone));

    assert property (@(posedge clock) disable iff (!rstN)
        waitCount <= cntWidth'(memLatency));

endmodule

`default_nettype wire

// ==== design/controlEncoder.sv ====
`default_nettype none
`timescale 1ns/10ps

module controlEncoder (
    input  logic                 clock,
    input  logic                 rstN,
    input  ctrlPkg::stateT       state,
    input  isaPkg::instrClassT   heldClass,
    input  logic                 eq,
    input  logic                 gt,
    output ctrlPkg::controlWordT ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic branchTaken;

    always_comb begin
        case (heldClass)
            BR_EQ:   branchTaken = eq;
            BR_NE:   branchTaken = !eq;
            BR_LE:   branchTaken = !gt;
            BR_GT:   branchTaken = gt;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        // Strobes stay low until reset is released
        if (rstN) begin
            case (state)
                FETCH_ISSUE: begin
                    ctrl.aluSrcA  = SRCA_PC;
                    ctrl.aluSrcB  = SRCB_CONST_FOUR;
                    ctrl.aluOp    = OP_ADD;
                    ctrl.pcSource = PC_ALU_RESULT;
                    ctrl.pcWrite  = 1'b1;
                end
                FETCH_LOAD: begin
                    ctrl.irWrite = 1'b1;
                end
                // Read A and B, branch target goes to ALUOut in parallel
                DECODE: begin
                    ctrl.regAWrite   = 1'b1;
                    ctrl.regBWrite   = 1'b1;
                    ctrl.aluSrcA     = SRCA_PC;
                    ctrl.aluSrcB     = SRCB_BRANCH_OFFSET;
                    ctrl.aluOp       = OP_ADD;
                    ctrl.aluOutWrite = 1'b1;
                end
                EXECUTE: begin
                    case (heldClass)
                        ALU_ADD, ALU_SUB, ALU_AND: begin
                            ctrl.aluSrcA     = SRCA_REG_A;
                            ctrl.aluSrcB     = SRCB_REG_B;
                            ctrl.aluOutWrite = 1'b1;
                            if (heldClass == ALU_ADD) begin
                                ctrl.aluOp = OP_ADD;
                            end else if (heldClass == ALU_SUB) begin
                                ctrl.aluOp = OP_SUB;
                            end else begin
                                ctrl.aluOp = OP_AND;
                            end
                        end
                        ADD_IMM: begin
                            ctrl.aluSrcA     = SRCA_REG_A;
                            ctrl.aluSrcB     = SRCB_IMMEDIATE;
                            ctrl.aluOp       = OP_ADD;
                            ctrl.aluOutWrite = 1'b1;
                        end
                        SET_LESS: begin
                            ctrl.aluSrcA  = SRCA_REG_A;
                            ctrl.aluSrcB  = SRCB_REG_B;
                            ctrl.aluOp    = OP_COMPARE;
                            ctrl.regWrite = 1'b1;
                            ctrl.regDest  = DEST_RD;
                            ctrl.regData  = DATA_LESS_FLAG;
                        end
                        JUMP_REG: begin
                            ctrl.pcSource = PC_REG_A;
                            ctrl.pcWrite  = 1'b1;
                        end
                        JUMP: begin
                            ctrl.pcSource = PC_JUMP_TARGET;
                            ctrl.pcWrite  = 1'b1;
                        end
                        // Return address is the already incremented PC
                        JUMP_LINK: begin
                            ctrl.pcSource    = PC_JUMP_TARGET;
                            ctrl.pcWrite     = 1'b1;
                            ctrl.aluSrcA     = SRCA_PC;
                            ctrl.aluOp       = OP_PASS_A;
                            ctrl.aluOutWrite = 1'b1;
                        end
                        MOVE_HI, MOVE_LO: begin
                            ctrl.regWrite   = 1'b1;
                            ctrl.regDest    = DEST_RD;
                            ctrl.regData    = DATA_HILO;
                            ctrl.hiLoSelect = (heldClass == MOVE_LO);
                        end
                        BR_EQ, BR_NE, BR_LE, BR_GT: begin
                            ctrl.aluSrcA = SRCA_REG_A;
                            ctrl.aluSrcB = SRCB_REG_B;
                            ctrl.aluOp   = OP_COMPARE;
                        end
                        MULTIPLY: begin
                            ctrl.multOp = 1'b1;
                        end
                        DIVIDE: begin
                            ctrl.divOp = 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end
                ALU_WRITEBACK: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regData  = DATA_ALU_OUT;
                    if (heldClass == ADD_IMM) begin
                        ctrl.regDest = DEST_RT;
                    end else begin
                        ctrl.regDest = DEST_RD;
                    end
                end
                LINK_WRITE: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDest  = DEST_RA;
                    ctrl.regData  = DATA_ALU_OUT;
                end
                // Keep the compare going so eq and gt stay valid
                BRANCH_RESOLVE: begin
                    ctrl.aluSrcA  = SRCA_REG_A;
                    ctrl.aluSrcB  = SRCB_REG_B;
                    ctrl.aluOp    = OP_COMPARE;
                    ctrl.pcSource = PC_ALU_OUT;
                    ctrl.pcWrite  = branchTaken;
                end
                MULDIV_WAIT: begin
                    ctrl.multOp = (heldClass == MULTIPLY);
                    ctrl.divOp  = (heldClass == DIVIDE);
                end
                HILO_WRITE: begin
                    ctrl.hiWrite     = 1'b1;
                    ctrl.loWrite     = 1'b1;
                    ctrl.hiLoFromDiv = (heldClass == DIVIDE);
                end
                EXCEPTION: begin
                    ctrl.pcSource = PC_EXC_VECTOR;
                    ctrl.pcWrite  = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (!rstN)
        !(ctrl.irWrite && ctrl.pcWrite) && !(ctrl.regWrite && ctrl.hiWrite));

endmodule

`default_nettype wire

// ==== design/controlUnit.sv ====
`default_nettype none
`timescale 1ns/10ps

module controlUnit #(
    parameter int memLatency = 2
) (
    input  logic                 clock,
    input  logic                 rstN,
    input  isaPkg::instrFieldsT  instr,
    input  ctrlPkg::aluFlagsT    aluFlags,
    input  logic                 multDone,
    input  logic                 divDone,
    output ctrlPkg::controlWordT ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrClassT instrClass;
    instrClassT heldClass;
    stateT      state;

    instrDecoder u_instrDecoder (
        .instr      (instr),
        .instrClass (instrClass)
    );

    sequencer #(
        .memLatency (memLatency)
    ) u_sequencer (
        .clock      (clock),
        .rstN       (rstN),
        .instrClass (instrClass),
        .overflow   (aluFlags.overflow),
        .multDone   (multDone),
        .divDone    (divDone),
        .state      (state),
        .heldClass  (heldClass)
    );

    controlEncoder u_controlEncoder (
        .clock     (clock),
        .rstN      (rstN),
        .state     (state),
        .heldClass (heldClass),
        .eq        (aluFlags.eq),
        .gt        (aluFlags.gt),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// ==== verif/tbControlUnit.sv ====
`default_nettype none
`timescale 1ns/10ps

module tbControlUnit;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int memLatency = 2;
    localparam int maxCycles = 200;

    logic        clock;
    logic        rstN;
    instrFieldsT instr;
    aluFlagsT    aluFlags;
    logic        multDone;
    logic        divDone;
    controlWordT ctrl;

    // Multiply/divide done model
    logic [7:0] lfsrState;
    int         doneWait;
    logic       opArmed;
    logic       doneForDiv;
    logic       doneNow;

    controlUnit #(
        .memLatency (memLatency)
    ) u_controlUnit (
        .clock    (clock),
        .rstN     (rstN),
        .instr    (instr),
        .aluFlags (aluFlags),
        .multDone (multDone),
        .divDone  (divDone),
        .ctrl     (ctrl)
    );

    always #50 clock = ~clock;

    task automatic stopRun;
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
            stopRun();
        end
    endtask

    function automatic logic [7:0] lfsrNext(input logic [7:0] s);
        // x^8 + x^6 + x^5 + x^4 + 1
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // Delay of 1 to 8 cycles from one LFSR step per bit
    task automatic drawDelay(output int delay);
        logic [2:0] bits;
        bits = '0;
        for (int i = 0; i < 3; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[1:0], lfsrState[0]};
        end
        delay = int'(bits) + 1;
    endtask

    function automatic logic [9:0] enableBits(input controlWordT c);
        return {c.pcWrite, c.irWrite, c.regAWrite, c.regBWrite, c.aluOutWrite,
                c.regWrite, c.hiWrite, c.loWrite, c.multOp, c.divOp};
    endfunction

    // Drive just after the rising edge and sample at the falling edge
    task automatic stepCycle(input instrFieldsT fields, input aluFlagsT flags,
                             output controlWordT sample);
        @(posedge clock);
        #5;
        instr = fields;
        aluFlags = flags;
        multDone = 1'b0;
        divDone = 1'b0;
        doneNow = 1'b0;
        if (doneWait > 0) begin
            doneWait = doneWait - 1;
            if (doneWait == 0) begin
                multDone = !doneForDiv;
                divDone = doneForDiv;
                doneNow = 1'b1;
            end
        end
        @(negedge clock);
        sample = ctrl;
        if ((sample.multOp || sample.divOp) && !opArmed) begin
            opArmed = 1'b1;
            doneForDiv = sample.divOp;
            drawDelay(doneWait);
        end else if (!sample.multOp && !sample.divOp) begin
            opArmed = 1'b0;
        end
    endtask

    // Runs from one FETCH_ISSUE cycle to the next
    task automatic runInstruction(input instrFieldsT fields, input aluFlagsT flags,
            input int expLen, input int expOp, input int expPc, input int expDest,
            input int expData, input int expSel, input int expHiLo);
        controlWordT cur;
        int   idx;
        int   decodeIdx;
        int   execIdx;
        int   doneAt;
        int   irWrites;
        int   pcWrites;
        int   regWrites;
        int   hiLoWrites;
        int   pcIdx;
        int   regIdx;
        int   lastPc;
        int   lastDest;
        int   lastData;
        int   lastSel;
        logic fetchSeen;
        logic opExpected;
        decodeIdx = memLatency + 1;
        execIdx = memLatency + 2;
        idx = 0;
        doneAt = -1;
        irWrites = 0;
        pcWrites = 0;
        regWrites = 0;
        hiLoWrites = 0;
        pcIdx = -1;
        regIdx = -1;
        lastPc = 0;
        lastDest = 0;
        lastData = 0;
        lastSel = 0;
        fetchSeen = 1'b0;
        while (!fetchSeen) begin
            if (idx >= maxCycles) begin
                $display("timeout, no instruction fetch within %0d cycles", maxCycles);
                stopRun();
            end
            stepCycle(fields, flags, cur);
            idx = idx + 1;
            if (cur.pcWrite && cur.pcSource == PC_ALU_RESULT) begin
                fetchSeen = 1'b1;
                checkValue("ctrl.aluSrcA", 32'(cur.aluSrcA), 32'(SRCA_PC));
                checkValue("ctrl.aluSrcB", 32'(cur.aluSrcB), 32'(SRCB_CONST_FOUR));
                checkValue("ctrl.aluOp", 32'(cur.aluOp), 32'(OP_ADD));
            end else begin
                if (doneNow) begin
                    doneAt = idx;
                end
                if (cur.irWrite) begin
                    irWrites = irWrites + 1;
                    checkValue("irWrite cycle", idx, memLatency);
                end
                // Registers A and B load only in DECODE
                checkValue("ctrl.regAWrite", 32'(cur.regAWrite), 32'(idx == decodeIdx));
                checkValue("ctrl.regBWrite", 32'(cur.regBWrite), 32'(idx == decodeIdx));
                if (idx == decodeIdx) begin
                    checkValue("ctrl.aluOutWrite", 32'(cur.aluOutWrite), 1);
                    checkValue("ctrl.aluSrcA", 32'(cur.aluSrcA), 32'(SRCA_PC));
                    checkValue("ctrl.aluSrcB", 32'(cur.aluSrcB), 32'(SRCB_BRANCH_OFFSET));
                    checkValue("ctrl.aluOp", 32'(cur.aluOp), 32'(OP_ADD));
                end
                if (idx == execIdx) begin
                    checkValue("ctrl.aluOp", 32'(cur.aluOp), expOp);
                end
                if (cur.pcWrite) begin
                    pcWrites = pcWrites + 1;
                    pcIdx = idx;
                    lastPc = int'(cur.pcSource);
                end
                if (cur.regWrite) begin
                    regWrites = regWrites + 1;
                    regIdx = idx;
                    lastDest = int'(cur.regDest);
                    lastData = int'(cur.regData);
                    lastSel = int'(cur.hiLoSelect);
                end
                if (cur.hiWrite || cur.loWrite) begin
                    hiLoWrites = hiLoWrites + 1;
                    checkValue("ctrl.hiWrite", 32'(cur.hiWrite), 1);
                    checkValue("ctrl.loWrite", 32'(cur.loWrite), 1);
                    checkValue("hiLoWrite cycle", idx, doneAt + 1);
                    checkValue("ctrl.hiLoFromDiv", 32'(cur.hiLoFromDiv), 32'(expHiLo == 2));
                end
                // Level held from EXECUTE through the done cycle
                opExpected = (expHiLo != 0) && (idx >= execIdx) &&
                             (doneAt < 0 || idx <= doneAt);
                checkValue("ctrl.multOp", 32'(cur.multOp), 32'(opExpected && expHiLo == 1));
                checkValue("ctrl.divOp", 32'(cur.divOp), 32'(opExpected && expHiLo == 2));
            end
        end
        checkValue("irWrite count", irWrites, 1);
        if (expLen != 0) begin
            checkValue("instruction length", idx, expLen);
        end else begin
            checkValue("instruction length", idx, doneAt + 2);
        end
        if (expPc == 'hf) begin
            checkValue("pcWrite count", pcWrites, 0);
        end else begin
            checkValue("pcWrite count", pcWrites, 1);
            checkValue("ctrl.pcSource", lastPc, expPc);
            // jal writes the PC before its link register
            if (expDest == 'hf) begin
                checkValue("pcWrite cycle", pcIdx, idx - 1);
            end
        end
        if (expDest == 'hf) begin
            checkValue("regWrite count", regWrites, 0);
        end else begin
            checkValue("regWrite count", regWrites, 1);
            checkValue("regWrite cycle", regIdx, idx - 1);
            checkValue("ctrl.regDest", lastDest, expDest);
            checkValue("ctrl.regData", lastData, expData);
            if (expData == 1) begin
                checkValue("ctrl.hiLoSelect", lastSel, expSel);
            end
        end
        checkValue("hiLoWrite count", hiLoWrites, (expHiLo != 0) ? 1 : 0);
    endtask

    initial begin
        int                 fd;
        int                 count;
        int                 lineLen;
        int                 fieldsRead;
        int                 opc, fn, ovf, eq, gt, len, op, pc, dest, data, sel, hl;
        logic [8*128-1:0]   lineBuf;
        instrFieldsT        fields;
        aluFlagsT           flags;
        clock = 1'b0;
        rstN = 1'b0;
        instr = '0;
        aluFlags = '0;
        multDone = 1'b0;
        divDone = 1'b0;
        lfsrState = 8'd61;
        doneWait = 0;
        opArmed = 1'b0;
        doneForDiv = 1'b0;
        doneNow = 1'b0;
        repeat (16) begin
            @(negedge clock);
            checkValue("reset enables", 32'(enableBits(ctrl)), 0);
        end
        @(posedge clock);
        #5;
        rstN = 1'b1;
        @(negedge clock);
        checkValue("ctrl.pcWrite", 32'(ctrl.pcWrite), 1);
        checkValue("ctrl.pcSource", 32'(ctrl.pcSource), 32'(PC_ALU_RESULT));

        fd = $fopen("verif/controlTrace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            stopRun();
        end
        count = 0;
        while (!$feof(fd)) begin
            lineBuf = '0;
            lineLen = $fgets(lineBuf, fd);
            if (lineLen > 0) begin
                // Comment and blank lines give fewer fields
                fieldsRead = $sscanf(lineBuf, "%h %h %h %h %h %d %h %h %h %h %h %h",
                                     opc, fn, ovf, eq, gt, len, op, pc, dest, data, sel, hl);
                if (fieldsRead == 12) begin
                    fields.opcode = opcodeT'(opc[5:0]);
                    fields.funct = functT'(fn[5:0]);
                    flags.overflow = ovf[0];
                    flags.eq = eq[0];
                    flags.gt = gt[0];
                    runInstruction(fields, flags, len, op, pc, dest, data, sel, hl);
                    count = count + 1;
                end
            end
        end
        $fclose(fd);
        if (count == 0) begin
            $display("the trace file held no instructions");
            stopRun();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/isaPkg.sv
design/ctrlPkg.sv
design/instrDecoder.sv
design/sequencer.sv
design/controlEncoder.sv
design/controlUnit.sv
verif/tbControlUnit.sv

// ==== Makefile ====
# Verilator build and run for the multicycle control unit

SOURCES := $(wildcard design/*.sv verif/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/VtbControlUnit: filelist.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module tbControlUnit -f filelist.f

# The simulation passes only if its output holds the pass line
run: obj_dir/VtbControlUnit
	@out="$$(./obj_dir/VtbControlUnit)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --top-module controlUnit -f filelist.f

clean:
	rm -rf obj_dir

// ==== verif/controlTrace.txt ====
// opc funct ovf eq gt len aluOp pcSrc regDst regData hiLoSel hiLo  (hex, len decimal)
// len 0 for mult/div, f for no pcWrite or no regWrite, hiLo 1 mult, 2 div
00 20 0 0 0 6 1 f 1 0 0 0 add
00 22 0 0 0 6 2 f 1 0 0 0 sub
00 24 0 0 0 6 3 f 1 0 0 0 and
08 00 0 0 0 6 1 f 0 0 0 0 addi
09 00 0 0 0 6 1 f 0 0 0 0 addiu
00 20 1 0 0 6 1 4 f 0 0 0 add overflow
00 22 1 0 0 6 2 4 f 0 0 0 sub overflow
09 00 1 0 0 6 1 4 f 0 0 0 addiu overflow
00 2a 0 0 0 5 7 f 1 2 0 0 slt
04 00 0 1 0 6 7 1 f 0 0 0 beq taken
04 00 0 0 1 6 7 f f 0 0 0 beq not taken
05 00 0 0 0 6 7 1 f 0 0 0 bne taken
05 00 0 1 0 6 7 f f 0 0 0 bne not taken
06 00 0 0 0 6 7 1 f 0 0 0 ble taken less
06 00 0 1 0 6 7 1 f 0 0 0 ble taken equal
06 00 0 0 1 6 7 f f 0 0 0 ble not taken
07 00 0 0 1 6 7 1 f 0 0 0 bgt taken
07 00 0 1 0 6 7 f f 0 0 0 bgt not taken equal
07 00 0 0 0 6 7 f f 0 0 0 bgt not taken less
02 00 0 0 0 5 0 2 f 0 0 0 j
00 08 0 0 0 5 0 3 f 0 0 0 jr
03 00 0 0 0 6 0 2 2 0 0 0 jal
00 18 0 0 0 0 0 f f 0 0 1 mult
00 10 0 0 0 5 0 f 1 1 0 0 mfhi
00 12 0 0 0 5 0 f 1 1 1 0 mflo
00 1a 0 0 0 0 0 f f 0 0 2 div
00 10 0 0 0 5 0 f 1 1 0 0 mfhi
00 12 0 0 0 5 0 f 1 1 1 0 mflo
3f 00 0 0 0 6 0 4 f 0 0 0 unknown opcode
00 3f 0 0 0 6 0 4 f 0 0 0 unknown funct
00 18 0 0 0 0 0 f f 0 0 1 mult
00 1a 0 0 0 0 0 f f 0 0 2 div
